//--- design/input_params.svh
`ifndef INPUT_PARAMS_SVH
`define INPUT_PARAMS_SVH

// Game input field widths
`define NOTE_KEYS 7
`define ARROW_KEYS 4
`define USER_ID_W 4

// Flops in front of every asynchronous pin
`define SYNC_STAGES 2

// One PS/2 data byte
`define PS2_CODE_W 8

`endif

//--- design/ps2_types_pkg.sv
`include "input_params.svh"

package ps2_types_pkg;

    // Receiver FSM, one state per field of the 11-bit frame
    typedef enum logic [1:0] {
        IDLE,
        DATA,
        PARITY,
        STOP
    } ps2_state_e;

    // Set-2 scan codes used by the game
    typedef enum logic [`PS2_CODE_W-1:0] {
        KEY_1        = 8'h16,
        KEY_2        = 8'h1e,
        KEY_3        = 8'h26,
        KEY_4        = 8'h25,
        KEY_5        = 8'h2e,
        KEY_6        = 8'h36,
        KEY_7        = 8'h3d,
        KEY_MINUS    = 8'h4e,
        KEY_PLUS     = 8'h55,
        PREFIX_EXT   = 8'he0,
        PREFIX_BREAK = 8'hf0,
        // Arrows only count behind an E0 prefix
        KEY_UP       = 8'h75,
        KEY_DOWN     = 8'h72,
        KEY_LEFT     = 8'h6b,
        KEY_RIGHT    = 8'h74
    } keycode_e;

endpackage

//--- design/user_input_pkg.sv
`include "input_params.svh"

package user_input_pkg;

    // One frame worth of player input
    typedef struct packed {
        // Bit 0 up, 1 down, 2 left, 3 right
        logic [`ARROW_KEYS-1:0] arrow_keys;
        // Bit 0 is note 1
        logic [`NOTE_KEYS-1:0]  note_keys;
        logic                   oct_up;
        logic                   oct_down;
        logic [`USER_ID_W-1:0]  user_id;
    } user_input_t;

endpackage

//--- design/ps2_key_if.sv
`timescale 1ns/100ps
`include "input_params.svh"

interface ps2_key_if;

    logic [`PS2_CODE_W-1:0] code;
    // Single-cycle strobe, no back-pressure
    logic                   valid;
    // F0 seen before this code
    logic                   released;
    // E0 seen before this code
    logic                   extended;

    modport tx (
        output code, valid, released, extended
    );

    modport rx (
        input code, valid, released, extended
    );

endinterface

//--- design/ps2_receiver.sv
`timescale 1ns/100ps
`include "input_params.svh"

module ps2_receiver (
    input  logic   clk,
    input  logic   sys_rst,
    input  logic   ps2_clk,
    input  logic   ps2_data,
    ps2_key_if.tx  key,
    output logic   ps2_err
);
    import ps2_types_pkg::*;

    logic [`SYNC_STAGES-1:0] clk_sync;
    logic [`SYNC_STAGES-1:0] data_sync;
    logic                    clk_prev;
    logic                    clk_fall;
    logic                    data_s;

    ps2_state_e              state;
    logic [2:0]              bit_cnt;
    logic [`PS2_CODE_W-1:0]  shift_reg;
    logic                    parity_bit;
    logic                    frame_ok;
    logic                    ext_flag;
    logic                    brk_flag;

    // Both lines idle high, so the chains reset to ones
    always_ff @(posedge clk) begin
        if (sys_rst) begin
            clk_sync  <= '1;
            data_sync <= '1;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[`SYNC_STAGES-2:0], ps2_clk};
            data_sync <= {data_sync[`SYNC_STAGES-2:0], ps2_data};
            clk_prev  <= clk_sync[`SYNC_STAGES-1];
        end
    end

    assign clk_fall = clk_prev & ~clk_sync[`SYNC_STAGES-1];
    assign data_s   = data_sync[`SYNC_STAGES-1];

    // Odd parity over data plus parity bit, stop bit must be high
    assign frame_ok = (^{shift_reg, parity_bit}) & data_s;

    always_ff @(posedge clk) begin
        if (sys_rst) begin
            state     <= IDLE;
            bit_cnt   <= '0;
            ext_flag  <= 1'b0;
            brk_flag  <= 1'b0;
            key.valid <= 1'b0;
            ps2_err   <= 1'b0;
        end else begin
            key.valid <= 1'b0;
            ps2_err   <= 1'b0;
            if (clk_fall) begin
                case (state)
                    IDLE: begin
                        // Start bit is low
                        if (!data_s) begin
                            state   <= DATA;
                            bit_cnt <= '0;
                        end
                    end
                    DATA: begin
                        // LSB arrives first
                        shift_reg <= {data_s, shift_reg[`PS2_CODE_W-1:1]};
                        bit_cnt   <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= PARITY;
                        end
                    end
                    PARITY: begin
                        parity_bit <= data_s;
                        state      <= STOP;
                    end
                    STOP: begin
                        state <= IDLE;
                        if (!frame_ok) begin
                            // Drop the frame and any pending prefix
                            ps2_err  <= 1'b1;
                            ext_flag <= 1'b0;
                            brk_flag <= 1'b0;
                        end else if (shift_reg == PREFIX_EXT) begin
                            ext_flag <= 1'b1;
                        end else if (shift_reg == PREFIX_BREAK) begin
                            brk_flag <= 1'b1;
                        end else begin
                            key.valid    <= 1'b1;
                            key.code     <= shift_reg;
                            key.released <= brk_flag;
                            key.extended <= ext_flag;
                            ext_flag     <= 1'b0;
                            brk_flag     <= 1'b0;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // A frame ends either as a key event or as an error, never both
    assert property (@(posedge clk) disable iff (sys_rst) !(key.valid && ps2_err));

    // Events and errors only in the cycle after a stop-bit falling edge
    assert property (@(posedge clk) disable iff (sys_rst)
        (key.valid || ps2_err) |-> $past(clk_fall && state == STOP));

endmodule

//--- design/keycode_mapper.sv
`timescale 1ns/100ps

module keycode_mapper (
    input  logic                        clk,
    input  logic                        sys_rst,
    input  logic                        frame_tick,
    ps2_key_if.rx                       key,
    output user_input_pkg::user_input_t kbd_in
);
    import ps2_types_pkg::*;
    import user_input_pkg::*;

    keycode_e    code;
    user_input_t hit;
    user_input_t acc;

    assign code = keycode_e'(key.code);

    // Bits set by the event in this cycle; user_id stays zero
    always_comb begin
        hit = '0;
        if (key.valid && !key.released) begin
            if (key.extended) begin
                case (code)
                    KEY_UP:    hit.arrow_keys[0] = 1'b1;
                    KEY_DOWN:  hit.arrow_keys[1] = 1'b1;
                    KEY_LEFT:  hit.arrow_keys[2] = 1'b1;
                    KEY_RIGHT: hit.arrow_keys[3] = 1'b1;
                    default: ;
                endcase
            end else begin
                case (code)
                    KEY_1:     hit.note_keys[0] = 1'b1;
                    KEY_2:     hit.note_keys[1] = 1'b1;
                    KEY_3:     hit.note_keys[2] = 1'b1;
                    KEY_4:     hit.note_keys[3] = 1'b1;
                    KEY_5:     hit.note_keys[4] = 1'b1;
                    KEY_6:     hit.note_keys[5] = 1'b1;
                    KEY_7:     hit.note_keys[6] = 1'b1;
                    KEY_MINUS: hit.oct_down     = 1'b1;
                    KEY_PLUS:  hit.oct_up       = 1'b1;
                    default: ;
                endcase
            end
        end
    end

    // Sticky within a frame so short taps survive until the tick
    always_ff @(posedge clk) begin
        if (sys_rst) begin
            acc    <= '0;
            kbd_in <= '0;
        end else if (frame_tick) begin
            kbd_in <= acc;
            // Event on the tick cycle belongs to the new frame
            acc    <= hit;
        end else begin
            acc <= acc | hit;
        end
    end

endmodule

//--- design/board_sampler.sv
`timescale 1ns/100ps
`include "input_params.svh"

module board_sampler (
    input  logic                        clk,
    input  logic                        sys_rst,
    input  logic                        frame_tick,
    input  logic [`ARROW_KEYS-1:0]      btn_arr,
    input  logic [`NOTE_KEYS-1:0]       btn_notes,
    input  logic                        btn_oct_up,
    input  logic                        btn_oct_down,
    input  logic [`USER_ID_W-1:0]       sw_user_id,
    output user_input_pkg::user_input_t board_in
);
    import user_input_pkg::*;

    user_input_t pins;
    user_input_t sync_q [`SYNC_STAGES];

    assign pins = '{
        arrow_keys: btn_arr,
        note_keys:  btn_notes,
        oct_up:     btn_oct_up,
        oct_down:   btn_oct_down,
        user_id:    sw_user_id
    };

    // Whole record moves through the chain, bits are independent
    always_ff @(posedge clk) begin
        if (sys_rst) begin
            for (int i = 0; i < `SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
            board_in <= '0;
        end else begin
            sync_q[0] <= pins;
            for (int i = 1; i < `SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
            if (frame_tick) begin
                board_in <= sync_q[`SYNC_STAGES-1];
            end
        end
    end

endmodule

//--- design/input_resolver.sv
`timescale 1ns/100ps
`include "input_params.svh"

module input_resolver (
    input  logic                        clk,
    input  logic                        sys_rst,
    input  logic                        frame_tick,
    input  user_input_pkg::user_input_t kbd_in,
    input  user_input_pkg::user_input_t board_in,
    output user_input_pkg::user_input_t user_in,
    output user_input_pkg::user_input_t user_edge
);
    import user_input_pkg::*;

    logic [`ARROW_KEYS-1:0] arr_or;
    user_input_t            merged;
    user_input_t            edge_next;

    always_comb begin
        arr_or = kbd_in.arrow_keys | board_in.arrow_keys;
        // Keep the lowest set bit, which gives U over D over L over R
        merged.arrow_keys = arr_or & (~arr_or + 1'b1);
        merged.note_keys  = kbd_in.note_keys | board_in.note_keys;
        merged.oct_up     = kbd_in.oct_up | board_in.oct_up;
        merged.oct_down   = ~merged.oct_up & (kbd_in.oct_down | board_in.oct_down);
        // Switches are the only source of the player ID
        merged.user_id    = board_in.user_id;
    end

    // Rising bits against the record still held in user_in
    always_comb begin
        edge_next         = merged & ~user_in;
        edge_next.user_id = merged.user_id;
    end

    always_ff @(posedge clk) begin
        if (sys_rst) begin
            user_in   <= '0;
            user_edge <= '0;
        end else if (frame_tick) begin
            user_in   <= merged;
            user_edge <= edge_next;
        end
    end

    assert property (@(posedge clk) disable iff (sys_rst) $onehot0(user_in.arrow_keys));

    assert property (@(posedge clk) disable iff (sys_rst)
        !(user_in.oct_up && user_in.oct_down));

endmodule

//--- design/user_input_top.sv
`timescale 1ns/100ps
`include "input_params.svh"

module user_input_top (
    input  logic                        clk,
    input  logic                        sys_rst,
    input  logic                        ps2_clk,
    input  logic                        ps2_data,
    input  logic [`ARROW_KEYS-1:0]      btn_arr,
    input  logic [`NOTE_KEYS-1:0]       btn_notes,
    input  logic                        btn_oct_up,
    input  logic                        btn_oct_down,
    input  logic [`USER_ID_W-1:0]       sw_user_id,
    input  logic                        frame_tick,
    output user_input_pkg::user_input_t user_in,
    output user_input_pkg::user_input_t user_edge,
    output logic                        ps2_err
);
    import user_input_pkg::*;

    user_input_t kbd_in;
    user_input_t board_in;

    ps2_key_if key_bus ();

    ps2_receiver u_ps2_receiver (
        .clk      (clk),
        .sys_rst  (sys_rst),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .key      (key_bus.tx),
        .ps2_err  (ps2_err)
    );

    keycode_mapper u_keycode_mapper (
        .clk        (clk),
        .sys_rst    (sys_rst),
        .frame_tick (frame_tick),
        .key        (key_bus.rx),
        .kbd_in     (kbd_in)
    );

    board_sampler u_board_sampler (
        .clk          (clk),
        .sys_rst      (sys_rst),
        .frame_tick   (frame_tick),
        .btn_arr      (btn_arr),
        .btn_notes    (btn_notes),
        .btn_oct_up   (btn_oct_up),
        .btn_oct_down (btn_oct_down),
        .sw_user_id   (sw_user_id),
        .board_in     (board_in)
    );

    // Registers one tick after the sources publish
    input_resolver u_input_resolver (
        .clk        (clk),
        .sys_rst    (sys_rst),
        .frame_tick (frame_tick),
        .kbd_in     (kbd_in),
        .board_in   (board_in),
        .user_in    (user_in),
        .user_edge  (user_edge)
    );

endmodule

//--- verif/tb_user_input.sv
`timescale 1ns/100ps

module tb_user_input;
    import user_input_pkg::*;

    localparam int N_WINDOWS  = 120;
    localparam int MAX_FRAMES = 3;
    // One PS/2 frame is 11 bits of 20 cycles each
    localparam int WATCHDOG_CYCLES = (N_WINDOWS + 1) * (MAX_FRAMES * 220 + 40);

    logic        clk;
    logic        sys_rst;
    logic        ps2_clk;
    logic        ps2_data;
    logic [3:0]  btn_arr;
    logic [6:0]  btn_notes;
    logic        btn_oct_up;
    logic        btn_oct_down;
    logic [3:0]  sw_user_id;
    logic        frame_tick;
    user_input_t user_in;
    user_input_t user_edge;
    logic        ps2_err;

    // Reference model state
    logic [31:0] rng_state = 32'h7633_21c0;
    user_input_t kbd_acc;
    user_input_t pub_kbd;
    user_input_t pub_board;
    user_input_t cur_board;
    user_input_t prev_in;
    user_input_t exp_in;
    user_input_t exp_edge;
    logic        ext_pending;
    logic        brk_pending;
    int          err_expected;
    int          err_seen;
    int          kbd_hits;

    user_input_top UUT (
        .clk          (clk),
        .sys_rst      (sys_rst),
        .ps2_clk      (ps2_clk),
        .ps2_data     (ps2_data),
        .btn_arr      (btn_arr),
        .btn_notes    (btn_notes),
        .btn_oct_up   (btn_oct_up),
        .btn_oct_down (btn_oct_down),
        .sw_user_id   (sw_user_id),
        .frame_tick   (frame_tick),
        .user_in      (user_in),
        .user_edge    (user_edge),
        .ps2_err      (ps2_err)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Mostly game codes, some prefixes, now and then any byte
    function automatic logic [7:0] pick_code(input logic [31:0] r);
        if (r[4:0] < 5'd6) begin
            return 8'he0;
        end else if (r[4:0] < 5'd9) begin
            return 8'hf0;
        end else if (r[4:0] == 5'd31) begin
            return r[23:16];
        end
        case (r[15:8] % 13)
            0: return 8'h16;
            1: return 8'h1e;
            2: return 8'h26;
            3: return 8'h25;
            4: return 8'h2e;
            5: return 8'h36;
            6: return 8'h3d;
            7: return 8'h4e;
            8: return 8'h55;
            9: return 8'h75;
            10: return 8'h72;
            11: return 8'h6b;
            default: return 8'h74;
        endcase
    endfunction

    // Set-2 code to record bits
    function automatic user_input_t key_bits(input logic [7:0] code, input logic ext);
        user_input_t k;
        k = '0;
        if (ext) begin
            case (code)
                8'h75: k.arrow_keys[0] = 1'b1;
                8'h72: k.arrow_keys[1] = 1'b1;
                8'h6b: k.arrow_keys[2] = 1'b1;
                8'h74: k.arrow_keys[3] = 1'b1;
                default: ;
            endcase
        end else begin
            case (code)
                8'h16: k.note_keys[0] = 1'b1;
                8'h1e: k.note_keys[1] = 1'b1;
                8'h26: k.note_keys[2] = 1'b1;
                8'h25: k.note_keys[3] = 1'b1;
                8'h2e: k.note_keys[4] = 1'b1;
                8'h36: k.note_keys[5] = 1'b1;
                8'h3d: k.note_keys[6] = 1'b1;
                8'h4e: k.oct_down = 1'b1;
                8'h55: k.oct_up = 1'b1;
                default: ;
            endcase
        end
        return k;
    endfunction

    function automatic user_input_t merge_records(input user_input_t kbd, input user_input_t brd);
        user_input_t m;
        logic [3:0]  a;
        a = kbd.arrow_keys | brd.arrow_keys;
        m = '0;
        if (a[0]) m.arrow_keys = 4'b0001;
        else if (a[1]) m.arrow_keys = 4'b0010;
        else if (a[2]) m.arrow_keys = 4'b0100;
        else if (a[3]) m.arrow_keys = 4'b1000;
        m.note_keys = kbd.note_keys | brd.note_keys;
        m.oct_up    = kbd.oct_up | brd.oct_up;
        m.oct_down  = !m.oct_up && (kbd.oct_down || brd.oct_down);
        m.user_id   = brd.user_id;
        return m;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s expected 0x%0h, actual 0x%0h",
                     $time, name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    // Start, 8 data bits LSB first, odd parity, stop
    task automatic send_ps2(input logic [7:0] data, input logic bad_parity);
        logic [10:0] bits;
        bits = {1'b1, ~^data ^ bad_parity, data, 1'b0};
        for (int i = 0; i < 11; i++) begin
            ps2_data = bits[i];
            repeat (10) @(negedge clk);
            ps2_clk = 1'b0;
            repeat (10) @(negedge clk);
            ps2_clk = 1'b1;
        end
    endtask

    // Prefix tracking and key accumulation as the receiver should see it
    task track_frame(input logic [7:0] data, input logic bad_parity);
        if (bad_parity) begin
            err_expected++;
            ext_pending = 1'b0;
            brk_pending = 1'b0;
        end else if (data == 8'he0) begin
            ext_pending = 1'b1;
        end else if (data == 8'hf0) begin
            brk_pending = 1'b1;
        end else begin
            if (!brk_pending && key_bits(data, ext_pending) != '0) begin
                kbd_acc = kbd_acc | key_bits(data, ext_pending);
                kbd_hits++;
            end
            ext_pending = 1'b0;
            brk_pending = 1'b0;
        end
    endtask

    // Error strobe lasts one cycle, so one sample per pulse
    always @(negedge clk) begin
        if (ps2_err === 1'b1) begin
            err_seen++;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog timeout: the run took longer than its cycle budget");
        $display("STATUS: FAIL");
        $fatal(1);
    end

    initial begin
        logic [31:0] r;
        logic [7:0]  code;
        logic        bad;
        int          n_frames;
        sys_rst = 1'b1;
        ps2_clk = 1'b1;
        ps2_data = 1'b1;
        btn_arr = '0;
        btn_notes = '0;
        btn_oct_up = 1'b0;
        btn_oct_down = 1'b0;
        sw_user_id = '0;
        frame_tick = 1'b0;
        kbd_acc = '0;
        pub_kbd = '0;
        pub_board = '0;
        prev_in = '0;
        ext_pending = 1'b0;
        brk_pending = 1'b0;
        err_expected = 0;
        err_seen = 0;
        kbd_hits = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        sys_rst = 1'b0;
        @(negedge clk);
        check_value("user_in", '0, user_in);
        check_value("user_edge", '0, user_edge);
        check_value("ps2_err", '0, ps2_err);

        for (int w = 0; w < N_WINDOWS; w++) begin
            r = next_random();
            // Half the windows keep the buttons held
            if (r[0]) begin
                btn_arr = r[4:1] & r[8:5];
                btn_notes = r[15:9] & r[22:16];
                btn_oct_up = r[23] & r[24];
                btn_oct_down = r[25];
                if (r[29:28] == 2'd0) begin
                    sw_user_id = r[31:28] ^ w[3:0];
                end
            end
            cur_board = '{
                arrow_keys: btn_arr,
                note_keys:  btn_notes,
                oct_up:     btn_oct_up,
                oct_down:   btn_oct_down,
                user_id:    sw_user_id
            };
            n_frames = r[27:26] % (MAX_FRAMES + 1);
            for (int f = 0; f < n_frames; f++) begin
                r = next_random();
                code = pick_code(r);
                bad = (r[30:28] == 3'd0);
                send_ps2(code, bad);
                track_frame(code, bad);
            end
            repeat (6) @(negedge clk);
            frame_tick = 1'b1;
            @(negedge clk);
            frame_tick = 1'b0;

            // Resolver registers what the sources published one tick earlier
            exp_in = merge_records(pub_kbd, pub_board);
            exp_edge = exp_in & ~prev_in;
            exp_edge.user_id = exp_in.user_id;
            check_value("user_in", exp_in, user_in);
            check_value("user_edge", exp_edge, user_edge);
            check_value("ps2_err count", err_expected, err_seen);
            prev_in = exp_in;
            pub_kbd = kbd_acc;
            pub_board = cur_board;
            kbd_acc = '0;
        end

        if (kbd_hits == 0 || err_expected == 0) begin
            $display("Stimulus never produced a keyboard hit or a parity error");
            $display("STATUS: FAIL");
            $fatal(1);
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

//--- vlog.f
+incdir+design
design/ps2_types_pkg.sv
design/user_input_pkg.sv
design/ps2_key_if.sv
design/ps2_receiver.sv
design/keycode_mapper.sv
design/board_sampler.sv
design/input_resolver.sv
design/user_input_top.sv
verif/tb_user_input.sv

//--- Bender.yml
package:
  name: user_input

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/ps2_types_pkg.sv
      - design/user_input_pkg.sv
      - design/ps2_key_if.sv
      - design/ps2_receiver.sv
      - design/keycode_mapper.sv
      - design/board_sampler.sv
      - design/input_resolver.sv
      - design/user_input_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/tb_user_input.sv
